// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = tb_spu_decode
RTL_TOP = spu_decode
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/even_decoder.sv
`timescale 1ns/1ps
module even_decoder (
	input spu_decode_pkg::instr_u word,
	output spu_decode_pkg::dec_instr_t dec
);
	logic hit;
	logic [8:0] op9;

	assign op9 = {word.ri16_18_f.op_hi, word.ri16_18_f.op_lo};

	always_comb begin
		dec = '0;
		hit = 1'b1;
		dec.rt = word.rr_f.rt;
		dec.ra = word.rr_f.ra;
		dec.rb = word.rr_f.rb;
		dec.rc = word.rr_f.rt;
		dec.reg_write = 1'b1;
		if (word.rrr_f.op inside {spu_decode_pkg::op_fma, spu_decode_pkg::op_mpya}) begin
			dec.format = spu_decode_pkg::fmt_rrr;
			dec.op = {7'd0, word.rrr_f.op};
			dec.unit = spu_decode_pkg::unit_fp;
			dec.rt = word.rrr_f.rt;	// rt sits right after the opcode
			dec.ra = word.rrr_f.ra;
			dec.rb = word.rrr_f.rb;
			dec.rc = word.rrr_f.rc;
			dec.ra_used = 1'b1;
			dec.rb_used = 1'b1;
			dec.rc_used = 1'b1;
		end else if (word.ri16_18_f.op_hi == spu_decode_pkg::op_ila) begin
			dec.format = spu_decode_pkg::fmt_ri18;
			dec.op = {4'd0, word.ri16_18_f.op_hi};
			dec.unit = spu_decode_pkg::unit_fx1;
			dec.imm = {word.ri16_18_f.op_lo, word.ri16_18_f.i16};	// already 18 bits
		end else if (op9 inside {spu_decode_pkg::op_ilh, spu_decode_pkg::op_iohl}) begin
			dec.format = spu_decode_pkg::fmt_ri16;
			dec.op = {2'd0, op9};
			dec.unit = spu_decode_pkg::unit_fx1;
			dec.imm = {{2{word.ri16_18_f.i16[15]}}, word.ri16_18_f.i16};
		end else if (word.ri10_f.op inside {spu_decode_pkg::op_ai, spu_decode_pkg::op_andi,
				spu_decode_pkg::op_mpyi}) begin
			dec.format = spu_decode_pkg::fmt_ri10;
			dec.op = {3'd0, word.ri10_f.op};
			dec.unit = (word.ri10_f.op == spu_decode_pkg::op_mpyi) ? spu_decode_pkg::unit_fp
				: spu_decode_pkg::unit_fx1;
			dec.ra_used = 1'b1;
			dec.imm = {{8{word.ri10_f.i10[9]}}, word.ri10_f.i10};
		end else begin
			dec.format = spu_decode_pkg::fmt_rr;
			dec.op = word.rr_f.op;
			dec.ra_used = 1'b1;
			dec.rb_used = 1'b1;
			case (word.rr_f.op)
				spu_decode_pkg::op_mpy, spu_decode_pkg::op_fa, spu_decode_pkg::op_fm:
					dec.unit = spu_decode_pkg::unit_fp;
				spu_decode_pkg::op_shl, spu_decode_pkg::op_rot:
					dec.unit = spu_decode_pkg::unit_fx2;
				spu_decode_pkg::op_avgb:
					dec.unit = spu_decode_pkg::unit_byte;
				spu_decode_pkg::op_cntb: begin
					dec.unit = spu_decode_pkg::unit_byte;
					dec.rb_used = 1'b0;	// single source
				end
				spu_decode_pkg::op_a, spu_decode_pkg::op_ah, spu_decode_pkg::op_sf,
				spu_decode_pkg::op_and, spu_decode_pkg::op_or, spu_decode_pkg::op_xor:
					dec.unit = spu_decode_pkg::unit_fx1;
				spu_decode_pkg::op_nop[31:21]: begin
					dec.ra_used = 1'b0;	// occupies the even pipe only
					dec.rb_used = 1'b0;
					dec.reg_write = 1'b0;
				end
				default: begin
					dec.format = spu_decode_pkg::fmt_ri7;
					dec.unit = spu_decode_pkg::unit_fx2;
					dec.rb_used = 1'b0;
					dec.imm = {{11{word.ri7_f.i7[6]}}, word.ri7_f.i7};
					hit = word.ri7_f.op inside {spu_decode_pkg::op_shli, spu_decode_pkg::op_roti};
				end
			endcase
		end
		if (!hit)
			dec = '0;
		dec.valid = hit;
	end
endmodule

// File: design/issue_control.sv
`timescale 1ns/1ps
module issue_control (
	input logic clk,
	input logic reset,
	input spu_decode_pkg::instr_u [1:0] instr_pair,
	input logic [spu_decode_pkg::pc_w-1:0] pc,
	input spu_decode_pkg::dec_instr_t [1:0] dec_even,
	input spu_decode_pkg::dec_instr_t [1:0] dec_odd,
	output spu_decode_pkg::instr_u [1:0] dec_word,	// pair handed to the decoders
	input logic [5:0] rd_busy,
	output logic [5:0][spu_decode_pkg::reg_addr_w-1:0] rd_addr,
	output logic [1:0] wr_en,
	output logic [1:0][spu_decode_pkg::reg_addr_w-1:0] wr_rt,
	output spu_decode_pkg::unit_t [1:0] wr_unit,
	output spu_decode_pkg::dec_instr_t issue_even,
	output spu_decode_pkg::dec_instr_t issue_odd,
	output logic stall,
	output logic [spu_decode_pkg::pc_w-1:0] stall_pc
);
	spu_decode_pkg::instr_u [1:0] buf_word;	// replay buffer holds words while stall is high
	spu_decode_pkg::dec_instr_t [1:0] slot;
	spu_decode_pkg::dec_instr_t issue_even_n, issue_odd_n;
	logic [spu_decode_pkg::pc_w-1:0] src_pc;
	logic [1:0] is_even, is_odd, waits_busy;
	logic pipe_clash, same_dest, reads_first;
	logic stall_first, stall_second, need_replay;

	assign dec_word = stall ? buf_word : instr_pair;
	assign src_pc = stall ? stall_pc : pc;

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			is_even[s] = dec_even[s].valid;
			is_odd[s] = dec_odd[s].valid && !dec_even[s].valid;
			slot[s] = is_even[s] ? dec_even[s] : dec_odd[s];
			rd_addr[3*s] = slot[s].ra;
			rd_addr[3*s+1] = slot[s].rb;
			rd_addr[3*s+2] = slot[s].rc;
			waits_busy[s] = |(rd_busy[3*s +: 3] &
				{slot[s].rc_used, slot[s].rb_used, slot[s].ra_used});
		end
	end

	assign pipe_clash = (is_even[0] && is_even[1]) || (is_odd[0] && is_odd[1]);
	assign same_dest = slot[0].reg_write && slot[1].reg_write && (slot[0].rt == slot[1].rt);
	assign reads_first = slot[0].reg_write &&
		((slot[1].ra_used && slot[1].ra == slot[0].rt) ||
		(slot[1].rb_used && slot[1].rb == slot[0].rt) ||
		(slot[1].rc_used && slot[1].rc == slot[0].rt));

	assign stall_first = waits_busy[0];	// holds the whole pair
	assign stall_second = slot[1].valid &&
		(pipe_clash || same_dest || reads_first || waits_busy[1]);
	assign need_replay = stall_first || stall_second;

	// route survivors with slot 0 first
	always_comb begin
		issue_even_n = '0;
		issue_odd_n = '0;
		if (!stall_first) begin
			if (is_even[0])
				issue_even_n = slot[0];
			else if (is_even[1] && !stall_second)
				issue_even_n = slot[1];
			if (is_odd[0])
				issue_odd_n = slot[0];
			else if (is_odd[1] && !stall_second)
				issue_odd_n = slot[1];
		end
		wr_en[0] = issue_even_n.valid && issue_even_n.reg_write;
		wr_rt[0] = issue_even_n.rt;
		wr_unit[0] = issue_even_n.unit;
		wr_en[1] = issue_odd_n.valid && issue_odd_n.reg_write;
		wr_rt[1] = issue_odd_n.rt;
		wr_unit[1] = issue_odd_n.unit;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_even <= '0;
			issue_odd <= '0;
			stall <= 1'b0;
			stall_pc <= '0;
		end else begin
			issue_even <= issue_even_n;
			issue_odd <= issue_odd_n;
			stall <= need_replay;
			stall_pc <= need_replay ? src_pc : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (stall_first) begin
			buf_word <= dec_word;
		end else if (stall_second) begin
			buf_word[0] <= dec_word[1];
			buf_word[1] <= '0;	// all-zero word decodes as nothing
		end
	end
endmodule

// File: design/odd_decoder.sv
`timescale 1ns/1ps
module odd_decoder (
	input spu_decode_pkg::instr_u word,
	output spu_decode_pkg::dec_instr_t dec
);
	logic hit;
	logic [8:0] op9;

	assign op9 = {word.ri16_18_f.op_hi, word.ri16_18_f.op_lo};

	always_comb begin
		dec = '0;
		hit = 1'b1;
		dec.rt = word.rr_f.rt;
		dec.ra = word.rr_f.ra;
		dec.rb = word.rr_f.rb;
		dec.rc = word.rr_f.rt;	// stores and brz read rt through rc
		dec.reg_write = 1'b1;
		if (word.ri10_f.op == spu_decode_pkg::op_lqd) begin
			dec.format = spu_decode_pkg::fmt_ri10;
			dec.op = {3'd0, word.ri10_f.op};
			dec.unit = spu_decode_pkg::unit_ls;
			dec.ra_used = 1'b1;
			dec.imm = {{8{word.ri10_f.i10[9]}}, word.ri10_f.i10};
		end else if (op9 inside {spu_decode_pkg::op_lqa, spu_decode_pkg::op_stqa,
				spu_decode_pkg::op_br, spu_decode_pkg::op_brz}) begin
			dec.format = spu_decode_pkg::fmt_ri16;
			dec.op = {2'd0, op9};
			dec.unit = (op9 inside {spu_decode_pkg::op_br, spu_decode_pkg::op_brz})
				? spu_decode_pkg::unit_br : spu_decode_pkg::unit_ls;
			dec.imm = {{2{word.ri16_18_f.i16[15]}}, word.ri16_18_f.i16};
			dec.reg_write = (op9 == spu_decode_pkg::op_lqa);
			dec.rc_used = op9 inside {spu_decode_pkg::op_stqa, spu_decode_pkg::op_brz};
		end else begin
			dec.format = spu_decode_pkg::fmt_rr;
			dec.op = word.rr_f.op;
			dec.unit = spu_decode_pkg::unit_perm;
			dec.ra_used = 1'b1;
			dec.rb_used = 1'b1;
			case (word.rr_f.op)
				spu_decode_pkg::op_rotqby: ;
				spu_decode_pkg::op_gbb:
					dec.rb_used = 1'b0;
				spu_decode_pkg::op_lqx:
					dec.unit = spu_decode_pkg::unit_ls;
				spu_decode_pkg::op_stqx: begin
					dec.unit = spu_decode_pkg::unit_ls;
					dec.rc_used = 1'b1;
					dec.reg_write = 1'b0;
				end
				spu_decode_pkg::op_bi: begin
					dec.unit = spu_decode_pkg::unit_br;
					dec.rb_used = 1'b0;
					dec.reg_write = 1'b0;
				end
				spu_decode_pkg::op_lnop[31:21]: begin
					dec.ra_used = 1'b0;	// takes the odd slot and nothing else
					dec.rb_used = 1'b0;
					dec.reg_write = 1'b0;
				end
				default: begin
					dec.format = spu_decode_pkg::fmt_ri7;
					dec.rb_used = 1'b0;
					dec.imm = {{11{word.ri7_f.i7[6]}}, word.ri7_f.i7};
					hit = (word.ri7_f.op == spu_decode_pkg::op_rotqbyi);
				end
			endcase
		end
		if (!hit)
			dec = '0;
		dec.valid = hit;
	end
endmodule

// File: design/spu_decode.sv
`timescale 1ns/1ps
module spu_decode (
	input logic clk,
	input logic reset,
	input spu_decode_pkg::instr_u [1:0] instr_pair,
	input logic [spu_decode_pkg::pc_w-1:0] pc,
	output spu_decode_pkg::dec_instr_t issue_even,
	output spu_decode_pkg::dec_instr_t issue_odd,
	output logic stall,
	output logic [spu_decode_pkg::pc_w-1:0] stall_pc
);
	spu_decode_pkg::instr_u [1:0] dec_word;
	spu_decode_pkg::dec_instr_t [1:0] dec_even;
	spu_decode_pkg::dec_instr_t [1:0] dec_odd;
	logic [5:0] rd_busy;
	logic [5:0][spu_decode_pkg::reg_addr_w-1:0] rd_addr;
	logic [1:0] wr_en;
	logic [1:0][spu_decode_pkg::reg_addr_w-1:0] wr_rt;
	spu_decode_pkg::unit_t [1:0] wr_unit;

	// each word goes through both tables at once
	for (genvar s = 0; s < 2; s++) begin : g_slot
		even_decoder u_even (
			.word(dec_word[s]),
			.dec(dec_even[s])
		);
		odd_decoder u_odd (
			.word(dec_word[s]),
			.dec(dec_odd[s])
		);
	end

	write_scoreboard u_scoreboard (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_rt(wr_rt),
		.wr_unit(wr_unit),
		.rd_addr(rd_addr),
		.rd_busy(rd_busy)
	);

	issue_control u_issue (
		.clk(clk),
		.reset(reset),
		.instr_pair(instr_pair),
		.pc(pc),
		.dec_even(dec_even),
		.dec_odd(dec_odd),
		.dec_word(dec_word),
		.rd_busy(rd_busy),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_rt(wr_rt),
		.wr_unit(wr_unit),
		.issue_even(issue_even),
		.issue_odd(issue_odd),
		.stall(stall),
		.stall_pc(stall_pc)
	);
endmodule

// File: design/spu_decode_pkg.sv
package spu_decode_pkg;

	localparam int instr_w = 32;
	localparam int reg_addr_w = 7;
	localparam int num_regs = 128;
	localparam int pc_w = 8;
	localparam int op_w = 11;
	localparam int imm_w = 18;
	localparam int lat_w = 3;

	typedef enum logic [1:0] {
		unit_fp = 2'd0,
		unit_fx2 = 2'd1,
		unit_byte = 2'd2,
		unit_fx1 = 2'd3
	} unit_t;

	// odd pipe reuses the same two-bit codes and the pipe tells them apart
	localparam unit_t unit_perm = unit_t'(2'd0);
	localparam unit_t unit_ls = unit_t'(2'd1);
	localparam unit_t unit_br = unit_t'(2'd2);

	localparam logic [lat_w-1:0] lat_fp = 3'd6, lat_fx2 = 3'd4, lat_byte = 3'd4, lat_fx1 = 3'd2;
	localparam logic [lat_w-1:0] lat_perm = 3'd4, lat_ls = 3'd6, lat_br = 3'd1;

	typedef enum logic [2:0] {
		fmt_rr, fmt_rrr, fmt_ri7, fmt_ri8, fmt_ri10, fmt_ri16, fmt_ri18
	} fmt_t;

	localparam logic [instr_w-1:0] op_nop = 32'h4020_0000;
	localparam logic [instr_w-1:0] op_lnop = 32'h0020_0000;

	localparam logic [3:0] op_mpya = 4'b1100, op_fma = 4'b1110;
	localparam logic [6:0] op_ila = 7'b0100001;
	localparam logic [7:0] op_ai = 8'b00011100, op_andi = 8'b00010100, op_mpyi = 8'b01110100,
		op_lqd = 8'b00110100;
	localparam logic [8:0] op_ilh = 9'b010000011, op_iohl = 9'b011000001, op_br = 9'b001100100,
		op_brz = 9'b001000000, op_lqa = 9'b001100001, op_stqa = 9'b001000001;
	localparam logic [10:0] op_a = 11'b00011000000, op_ah = 11'b00011001000,
		op_sf = 11'b00001000000, op_and = 11'b00011000001, op_or = 11'b00001000001,
		op_xor = 11'b01001000001, op_mpy = 11'b01111000100, op_fa = 11'b01011000100,
		op_fm = 11'b01011000110, op_shl = 11'b00001011011, op_rot = 11'b00001011000,
		op_cntb = 11'b01010110100, op_avgb = 11'b00011010011, op_lqx = 11'b00111000100,
		op_stqx = 11'b00101000100, op_bi = 11'b00110101000, op_rotqby = 11'b00111011100,
		op_gbb = 11'b00110110010;
	localparam logic [10:0] op_shli = 11'b00001111011, op_roti = 11'b00001111000,
		op_rotqbyi = 11'b00111111100;

	typedef union packed {
		struct packed {
			logic [10:0] op;
			logic [reg_addr_w-1:0] rb, ra, rt;
		} rr_f;
		struct packed {
			logic [3:0] op;
			logic [reg_addr_w-1:0] rt, rb, ra, rc;
		} rrr_f;
		struct packed {
			logic [10:0] op;
			logic [6:0] i7;
			logic [reg_addr_w-1:0] ra, rt;
		} ri7_f;
		struct packed {
			logic [7:0] op;
			logic [9:0] i10;
			logic [reg_addr_w-1:0] ra, rt;
		} ri10_f;
		struct packed {
			logic [6:0] op_hi;	// whole opcode for ri18
			logic [1:0] op_lo;	// top of imm for ri18, opcode tail for ri16
			logic [15:0] i16;
			logic [reg_addr_w-1:0] rt;
		} ri16_18_f;
	} instr_u;

	typedef struct packed {
		logic valid;
		unit_t unit;
		fmt_t format;
		logic [op_w-1:0] op;
		logic [reg_addr_w-1:0] rt, ra, rb, rc;
		logic ra_used, rb_used, rc_used;
		logic reg_write;
		logic [imm_w-1:0] imm;
	} dec_instr_t;

endpackage

// File: design/write_scoreboard.sv
`timescale 1ns/1ps
module write_scoreboard (
	input logic clk,
	input logic reset,
	input logic [1:0] wr_en,	// [0] even pipe, [1] odd pipe
	input logic [1:0][spu_decode_pkg::reg_addr_w-1:0] wr_rt,
	input spu_decode_pkg::unit_t [1:0] wr_unit,
	input logic [5:0][spu_decode_pkg::reg_addr_w-1:0] rd_addr,
	output logic [5:0] rd_busy
);
	logic [spu_decode_pkg::lat_w-1:0] count [spu_decode_pkg::num_regs];
	logic [1:0][spu_decode_pkg::lat_w-1:0] load_lat;

	// load lat-1 so a reader can go exactly lat edges after its producer
	always_comb begin
		case (wr_unit[0])
			spu_decode_pkg::unit_fp: load_lat[0] = spu_decode_pkg::lat_fp - 1'b1;
			spu_decode_pkg::unit_fx2: load_lat[0] = spu_decode_pkg::lat_fx2 - 1'b1;
			spu_decode_pkg::unit_byte: load_lat[0] = spu_decode_pkg::lat_byte - 1'b1;
			default: load_lat[0] = spu_decode_pkg::lat_fx1 - 1'b1;
		endcase
		case (wr_unit[1])
			spu_decode_pkg::unit_perm: load_lat[1] = spu_decode_pkg::lat_perm - 1'b1;
			spu_decode_pkg::unit_ls: load_lat[1] = spu_decode_pkg::lat_ls - 1'b1;
			default: load_lat[1] = spu_decode_pkg::lat_br - 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < spu_decode_pkg::num_regs; r++) begin
			if (reset)
				count[r] <= '0;
			else if (wr_en[1] && wr_rt[1] == spu_decode_pkg::reg_addr_w'(r))
				count[r] <= load_lat[1];
			else if (wr_en[0] && wr_rt[0] == spu_decode_pkg::reg_addr_w'(r))
				count[r] <= load_lat[0];	// a rewrite reloads
			else if (count[r] != '0)
				count[r] <= count[r] - 1'b1;
		end
	end

	always_comb begin
		for (int k = 0; k < 6; k++)
			rd_busy[k] = (count[rd_addr[k]] != '0);
	end
endmodule

// File: tb.f
design/spu_decode_pkg.sv
design/even_decoder.sv
design/odd_decoder.sv
design/write_scoreboard.sv
design/issue_control.sv
design/spu_decode.sv
verification/tb_spu_decode.sv

// File: verification/decode_vectors.txt
# rst word0 word1 pc | even: valid unit op rt imm | odd: valid unit op rt imm | stall stall_pc
# all hex, one line per cycle, a held pair repeats while stall is high
0 18008083 38818205 10 1 3 0c0 03 00000 1 1 1c4 05 00000 0 00
0 3b824407 5883058a 14 1 0 2c4 0a 00000 1 0 1dc 07 00000 0 00
0 1900808d 1820808e 18 1 3 0c8 0d 00000 0 0 000 00 00000 1 18
0 1900808d 1820808e 18 1 3 0c1 0e 00000 0 0 000 00 00000 0 00
0 18008094 38818214 1c 1 3 0c0 14 00000 0 0 000 00 00000 1 1c
0 18008094 38818214 1c 0 0 000 00 00000 1 1 1c4 14 00000 0 00
0 18008095 38818a96 20 1 3 0c0 15 00000 0 0 000 00 00000 1 20
0 18008095 38818a96 20 0 0 000 00 00000 0 0 000 00 00000 1 20
0 18008095 38818a96 20 0 0 000 00 00000 1 1 1c4 16 00000 0 00
0 5883059e 00200000 24 1 0 2c4 1e 00000 1 0 001 00 00000 0 00
0 18008f1f 00000000 28 0 0 000 00 00000 0 0 000 00 00000 1 28
0 18008f1f 00000000 28 0 0 000 00 00000 0 0 000 00 00000 1 28
0 18008f1f 00000000 28 0 0 000 00 00000 0 0 000 00 00000 1 28
0 18008f1f 00000000 28 0 0 000 00 00000 0 0 000 00 00000 1 28
0 18008f1f 00000000 28 0 0 000 00 00000 0 0 000 00 00000 1 28
0 18008f1f 00000000 28 1 3 0c0 1f 00000 0 0 000 00 00000 0 00
0 430002a8 3f9f8429 2c 1 3 021 28 20005 1 0 1fc 29 3fffe 0 00
0 41c000aa 1cff40ab 30 1 3 083 2a 38001 0 0 000 00 00000 1 30
0 41c000aa 1cff40ab 30 1 3 01c 2b 3fffd 0 0 000 00 00000 0 00
0 0f7fc0ac ffffffff 34 1 1 07b 2c 3ffff 0 0 000 00 00000 0 00
0 e5a08084 34ff042e 38 1 0 00e 2d 00000 1 1 034 2e 3fffc 0 00
0 588305b2 00000000 3c 1 0 2c4 32 00000 0 0 000 00 00000 0 00
1 00000000 00000000 00 0 0 000 00 00000 0 0 000 00 00000 0 00
0 18009933 00000000 40 1 3 0c0 33 00000 0 0 000 00 00000 0 00
0 40200000 32000800 44 1 0 201 00 00000 1 2 064 00 00010 0 00

// File: verification/tb_spu_decode.sv
`timescale 1ns/1ps
module tb_spu_decode;
	localparam int num_vectors = 25;
	localparam int reset_cycles = 5;
	localparam int max_cycles = reset_cycles + num_vectors + 20;

	typedef struct packed {
		logic valid;
		logic [1:0] unit;
		logic [10:0] op;
		logic [6:0] rt;
		logic [17:0] imm;
	} pipe_exp_t;

	logic clk;
	logic reset;
	spu_decode_pkg::instr_u [1:0] instr_pair;
	logic [spu_decode_pkg::pc_w-1:0] pc;
	spu_decode_pkg::dec_instr_t issue_even;
	spu_decode_pkg::dec_instr_t issue_odd;
	logic stall;
	logic [spu_decode_pkg::pc_w-1:0] stall_pc;
	int errors = 0;
	int cycles = 0;
	int vectors = 0;
	int fd;

	spu_decode u_dut (
		.clk(clk),
		.reset(reset),
		.instr_pair(instr_pair),
		.pc(pc),
		.issue_even(issue_even),
		.issue_odd(issue_odd),
		.stall(stall),
		.stall_pc(stall_pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run hung after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pipe(input string pipe, input spu_decode_pkg::dec_instr_t got,
			input pipe_exp_t exp);
		compare({pipe, ".valid"}, 32'(got.valid), 32'(exp.valid));
		compare({pipe, ".unit"}, 32'(got.unit), 32'(exp.unit));
		compare({pipe, ".op"}, 32'(got.op), 32'(exp.op));
		compare({pipe, ".rt"}, 32'(got.rt), 32'(exp.rt));
		compare({pipe, ".imm"}, 32'(got.imm), 32'(exp.imm));
	endtask

	task automatic run_vectors();
		string line;
		logic [31:0] f [16];
		pipe_exp_t exp_even;
		pipe_exp_t exp_odd;
		int n;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == 8'h23)
				continue;	// comment or blank
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
				f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
			if (n != 16) begin
				$display("malformed line in the vector file: %s", line);
				errors++;
				continue;
			end
			reset = f[0][0];
			instr_pair[0] = f[1];
			instr_pair[1] = f[2];
			pc = f[3][7:0];
			exp_even = {f[4][0], f[5][1:0], f[6][10:0], f[7][6:0], f[8][17:0]};
			exp_odd = {f[9][0], f[10][1:0], f[11][10:0], f[12][6:0], f[13][17:0]};
			@(negedge clk);	// outputs settled one edge later
			vectors++;
			check_pipe("issue_even", issue_even, exp_even);
			check_pipe("issue_odd", issue_odd, exp_odd);
			compare("stall", 32'(stall), 32'(f[14][0]));
			compare("stall_pc", 32'(stall_pc), 32'(f[15][7:0]));
		end
	endtask

	initial begin
		reset = 1'b1;
		instr_pair = '0;
		pc = '0;
		fd = $fopen("verification/decode_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file");
			errors++;
		end else begin
			repeat (reset_cycles) @(negedge clk);
			reset = 1'b0;
			run_vectors();
			$fclose(fd);
			if (vectors != num_vectors) begin
				$display("only %0d of %0d vectors were applied", vectors, num_vectors);
				errors++;
			end
		end
		$display("%0d vectors checked, %0d errors", vectors, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule
